// ==== src.f ====
+incdir+design
design/axil_pkg.sv
design/axil_req_slice.sv
design/csr_route_fsm.sv
design/csr_regfile.sv
design/fake_responder.sv
design/miss_counter.sv
design/csr_subsystem.sv
test/tb_csr_subsystem.sv

// ==== test/tb_csr_subsystem.sv ====
/*
 Random-stimulus testbench for the CSR endpoint, seed 58
 One transaction at a time, response readies toggle randomly
 Run length is bounded by a cycle counter
*/
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_subsystem
   import axil_pkg::*;
();

   // Planned transactions over all five tests, 60 cycles allowed for each
   localparam int NUM_TXN    = 321;
   localparam int MAX_CYCLES = 60 * NUM_TXN;

   logic     clk;
   logic     rst_n;
   logic     aw_valid;
   logic     aw_ready;
   axil_ax_t aw_data;
   logic     w_valid;
   logic     w_ready;
   axil_w_t  w_data;
   logic     b_valid;
   logic     b_ready;
   axil_b_t  b_data;
   logic     ar_valid;
   logic     ar_ready;
   axil_ax_t ar_data;
   logic     r_valid;
   logic     r_ready;
   axil_r_t  r_data;

   integer seed;
   int     err_count;
   int     check_count;
   int     cycle_count;
   int     rd_issued;
   int     wr_issued;
   int     r_seen;
   int     b_seen;

   // Reference model state
   logic [`CSR_DATA_W-1:0] scratch_model [2];
   logic [`CSR_DATA_W-1:0] miss_model;

   // Stall tracking for the stability monitor
   logic    r_stall;
   logic    b_stall;
   axil_r_t r_held;
   axil_b_t b_held;

   csr_subsystem dut (
      .clk, .rst_n,
      .aw_valid, .aw_ready, .aw_data,
      .w_valid, .w_ready, .w_data,
      .b_valid, .b_ready, .b_data,
      .ar_valid, .ar_ready, .ar_data,
      .r_valid, .r_ready, .r_data
   );

   always #10 clk = ~clk;

   // ------------------------------
   // Model helpers
   // ------------------------------
   function automatic logic [`CSR_DATA_W-1:0] saturating_inc(input logic [`CSR_DATA_W-1:0] v);
      if (v == '1) begin
         return v;
      end
      return v + 1'b1;
   endfunction

   // Byte lanes with a set strobe take the new data
   function automatic logic [`CSR_DATA_W-1:0] apply_strobes(
      input logic [`CSR_DATA_W-1:0] old,
      input logic [`CSR_DATA_W-1:0] wdata,
      input logic [3:0]             strb
   );
      logic [`CSR_DATA_W-1:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old & ~mask) | (wdata & mask);
   endfunction

   // Expected read data for an address, from model state
   function automatic logic [`CSR_DATA_W-1:0] read_value(input logic [`CSR_ADDR_W-1:0] addr);
      if (addr >= `CSR_IMPL_LIMIT) begin
         return '0;
      end
      case (addr[3:2])
         2'd0:    return `CSR_ID_VALUE;
         2'd1:    return scratch_model[0];
         2'd2:    return scratch_model[1];
         default: return miss_model;
      endcase
   endfunction

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_r(input axil_r_t got, input logic [`CSR_DATA_W-1:0] exp_data);
      check_count++;
      if (got.data !== exp_data || got.resp !== RESP_OKAY) begin
         err_count++;
         $display("ERROR at %0t: read data %h resp %0d, expected %h resp OKAY",
                  $time, got.data, got.resp, exp_data);
      end
   endtask

   task automatic check_b(input axil_b_t got);
      check_count++;
      if (got.resp !== RESP_OKAY) begin
         err_count++;
         $display("ERROR at %0t: write resp %0d, expected OKAY", $time, got.resp);
      end
   endtask

   task automatic check_low(input logic value, input string what);
      check_count++;
      if (value !== 1'b0) begin
         err_count++;
         $display("ERROR at %0t: %s is %b after reset, expected 0", $time, what, value);
      end
   endtask

   // ------------------------------
   // Drivers, called and returning on a rising edge
   // ------------------------------
   task automatic do_read(input logic [`CSR_ADDR_W-1:0] addr);
      logic [`CSR_DATA_W-1:0] exp_data;
      axil_r_t                got;
      exp_data = read_value(addr);
      ar_valid <= 1'b1;
      ar_data  <= '{addr: addr};
      do begin
         @(posedge clk);
      end while (!(ar_valid && ar_ready));
      ar_valid <= 1'b0;
      rd_issued++;
      do begin
         @(posedge clk);
      end while (!(r_valid && r_ready));
      got = r_data;
      check_r(got, exp_data);
      if (addr >= `CSR_IMPL_LIMIT) begin
         miss_model = saturating_inc(miss_model);
      end
   endtask

   task automatic do_write(
      input logic [`CSR_ADDR_W-1:0] addr,
      input logic [`CSR_DATA_W-1:0] data,
      input logic [3:0]             strb
   );
      logic    aw_taken;
      logic    w_taken;
      axil_b_t got;
      aw_taken = 1'b0;
      w_taken  = 1'b0;
      aw_valid <= 1'b1;
      aw_data  <= '{addr: addr};
      w_valid  <= 1'b1;
      w_data   <= '{data: data, strb: strb};
      // Both slices accept on their own
      while (!(aw_taken && w_taken)) begin
         @(posedge clk);
         if (aw_valid && aw_ready) begin
            aw_taken = 1'b1;
            aw_valid <= 1'b0;
         end
         if (w_valid && w_ready) begin
            w_taken = 1'b1;
            w_valid <= 1'b0;
         end
      end
      wr_issued++;
      do begin
         @(posedge clk);
      end while (!(b_valid && b_ready));
      got = b_data;
      check_b(got);
      if (addr >= `CSR_IMPL_LIMIT) begin
         miss_model = saturating_inc(miss_model);
      end else begin
         case (addr[3:2])
            2'd1:    scratch_model[0] = apply_strobes(scratch_model[0], data, strb);
            2'd2:    scratch_model[1] = apply_strobes(scratch_model[1], data, strb);
            2'd3:    miss_model = '0;
            default: ;
         endcase
      end
   endtask

   task automatic report_test(input string name, input int start_errs);
      $display("%s: %s, %0d errors", name,
               (err_count == start_errs) ? "PASS" : "FAIL", err_count - start_errs);
   endtask

   // ------------------------------
   // Back-pressure, monitor and timeout
   // ------------------------------
   always @(posedge clk) begin
      if (rst_n) begin
         r_ready <= ($random(seed) % 2) != 0;
         b_ready <= ($random(seed) % 2) != 0;
      end
   end

   // Stalled responses hold, handshakes are counted for loss or duplication
   always @(posedge clk) begin
      if (rst_n) begin
         if (r_stall && (!r_valid || r_data !== r_held)) begin
            err_count++;
            $display("ERROR at %0t: stalled read response changed or dropped", $time);
         end
         if (b_stall && (!b_valid || b_data !== b_held)) begin
            err_count++;
            $display("ERROR at %0t: stalled write response changed or dropped", $time);
         end
         if (r_valid && r_ready) begin
            r_seen++;
         end
         if (b_valid && b_ready) begin
            b_seen++;
         end
         r_stall <= r_valid && !r_ready;
         b_stall <= b_valid && !b_ready;
         r_held  <= r_data;
         b_held  <= b_data;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic [31:0]            rnd;
      logic [`CSR_ADDR_W-1:0] addr;
      int                     start_errs;
      seed             = 58;
      clk              = 1'b0;
      rst_n            = 1'b0;
      aw_valid         = 1'b0;
      aw_data          = '0;
      w_valid          = 1'b0;
      w_data           = '0;
      b_ready          = 1'b0;
      ar_valid         = 1'b0;
      ar_data          = '0;
      r_ready          = 1'b0;
      err_count        = 0;
      check_count      = 0;
      cycle_count      = 0;
      rd_issued        = 0;
      wr_issued        = 0;
      r_seen           = 0;
      b_seen           = 0;
      r_stall          = 1'b0;
      b_stall          = 1'b0;
      scratch_model[0] = '0;
      scratch_model[1] = '0;
      miss_model       = '0;

      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // Test 1, state right after reset
      start_errs = err_count;
      @(posedge clk);
      check_low(aw_ready, "aw_ready");
      check_low(w_ready, "w_ready");
      check_low(ar_ready, "ar_ready");
      check_low(b_valid, "b_valid");
      check_low(r_valid, "r_valid");
      do_read(12'h000);
      do_read(12'h00C);
      report_test("Test 1 reset state", start_errs);

      // Test 2, scratch write and read-back
      start_errs = err_count;
      for (int i = 0; i < 40; i++) begin
         rnd  = $random(seed);
         addr = rnd[31] ? 12'h008 : 12'h004;
         do_write(addr, $random(seed), rnd[3:0]);
         do_read(addr);
      end
      // ID is read only
      do_write(12'h000, $random(seed), 4'hF);
      do_read(12'h000);
      report_test("Test 2 scratch registers", start_errs);

      // Test 3, unimplemented window
      start_errs = err_count;
      for (int i = 0; i < 30; i++) begin
         rnd  = $random(seed);
         addr = rnd[27:16] | `CSR_IMPL_LIMIT;
         if (rnd[0]) begin
            do_read(addr);
         end else begin
            do_write(addr, $random(seed), rnd[7:4]);
         end
      end
      do_read(12'h00C);
      report_test("Test 3 unimplemented addresses", start_errs);

      // Test 4, mixed traffic, readies keep toggling
      start_errs = err_count;
      for (int i = 0; i < 200; i++) begin
         rnd = $random(seed);
         if (rnd[0]) begin
            addr = rnd[23:12];
         end else begin
            addr      = '0;
            addr[3:2] = rnd[5:4];
         end
         if (rnd[1]) begin
            do_read(addr);
         end else begin
            do_write(addr, $random(seed), rnd[11:8]);
         end
      end
      report_test("Test 4 mixed traffic", start_errs);

      // Test 5, clear then count three misses
      start_errs = err_count;
      do_write(12'h00C, $random(seed), 4'hF);
      do_read(12'h00C);
      do_read(12'h100);
      do_write(12'h204, $random(seed), 4'h3);
      do_read(12'hFFC);
      do_read(12'h00C);
      report_test("Test 5 miss counter clear", start_errs);

      // Idle a little so a late duplicate would still be counted
      repeat (10) @(posedge clk);
      if (r_seen != rd_issued || b_seen != wr_issued) begin
         err_count++;
         $display("Response count mismatch: %0d reads and %0d writes issued, %0d and %0d answered",
                  rd_issued, wr_issued, r_seen, b_seen);
      end

      $display("Checks: %0d, errors: %0d, reads: %0d, writes: %0d",
               check_count, err_count, rd_issued, wr_issued);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== design/csr_subsystem.sv ====
/*
 AXI-Lite CSR endpoint, one read and one write outstanding
 Unimplemented addresses are counted and answered with OKAY
*/
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_subsystem
   import axil_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     aw_valid,
   output logic     aw_ready,
   input  axil_ax_t aw_data,
   input  logic     w_valid,
   output logic     w_ready,
   input  axil_w_t  w_data,
   output logic     b_valid,
   input  logic     b_ready,
   output axil_b_t  b_data,
   input  logic     ar_valid,
   output logic     ar_ready,
   input  axil_ax_t ar_data,
   output logic     r_valid,
   input  logic     r_ready,
   output axil_r_t  r_data
);

   // Slice outputs
   logic     sl_aw_valid, sl_aw_ready, sl_w_valid, sl_w_ready, sl_ar_valid, sl_ar_ready;
   axil_ax_t sl_aw_data, sl_ar_data;
   axil_w_t  sl_w_data;

   // Register file channels
   logic     reg_aw_valid, reg_aw_ready, reg_w_valid, reg_w_ready;
   logic     reg_ar_valid, reg_ar_ready, reg_b_valid, reg_b_ready;
   logic     reg_r_valid, reg_r_ready;
   axil_ax_t reg_aw_data, reg_ar_data;
   axil_w_t  reg_w_data;
   axil_b_t  reg_b_data;
   axil_r_t  reg_r_data;

   // Fake responder channels
   logic     fake_aw_valid, fake_aw_ready, fake_w_valid, fake_w_ready;
   logic     fake_ar_valid, fake_ar_ready, fake_b_valid, fake_b_ready;
   logic     fake_r_valid, fake_r_ready;
   axil_ax_t fake_aw_data, fake_ar_data;
   axil_w_t  fake_w_data;
   axil_b_t  fake_b_data;
   axil_r_t  fake_r_data;

   // Miss tracking
   logic [1:0]             miss_inc;
   logic                   miss_clr;
   logic [`CSR_DATA_W-1:0] miss_count;

   // ------------------------------
   // Request slices
   // ------------------------------
   axil_req_slice #(.payload_t(axil_ax_t)) u_aw_slice (
      .clk, .rst_n,
      .in_valid (aw_valid),    .in_ready (aw_ready),    .in_data (aw_data),
      .out_valid(sl_aw_valid), .out_ready(sl_aw_ready), .out_data(sl_aw_data)
   );

   axil_req_slice #(.payload_t(axil_w_t)) u_w_slice (
      .clk, .rst_n,
      .in_valid (w_valid),    .in_ready (w_ready),    .in_data (w_data),
      .out_valid(sl_w_valid), .out_ready(sl_w_ready), .out_data(sl_w_data)
   );

   axil_req_slice #(.payload_t(axil_ax_t)) u_ar_slice (
      .clk, .rst_n,
      .in_valid (ar_valid),    .in_ready (ar_ready),    .in_data (ar_data),
      .out_valid(sl_ar_valid), .out_ready(sl_ar_ready), .out_data(sl_ar_data)
   );

   // ------------------------------
   // Router and targets
   // ------------------------------
   csr_route_fsm u_route (
      .clk, .rst_n,
      .aw_valid(sl_aw_valid), .aw_ready(sl_aw_ready), .aw_data(sl_aw_data),
      .w_valid (sl_w_valid),  .w_ready (sl_w_ready),  .w_data (sl_w_data),
      .ar_valid(sl_ar_valid), .ar_ready(sl_ar_ready), .ar_data(sl_ar_data),
      .b_valid, .b_ready, .b_data, .r_valid, .r_ready, .r_data,
      .reg_aw_valid, .reg_aw_ready, .reg_aw_data,
      .reg_w_valid, .reg_w_ready, .reg_w_data,
      .reg_ar_valid, .reg_ar_ready, .reg_ar_data,
      .reg_b_valid, .reg_b_ready, .reg_b_data,
      .reg_r_valid, .reg_r_ready, .reg_r_data,
      .fake_aw_valid, .fake_aw_ready, .fake_aw_data,
      .fake_w_valid, .fake_w_ready, .fake_w_data,
      .fake_ar_valid, .fake_ar_ready, .fake_ar_data,
      .fake_b_valid, .fake_b_ready, .fake_b_data,
      .fake_r_valid, .fake_r_ready, .fake_r_data,
      .miss_inc
   );

   csr_regfile u_regfile (
      .clk, .rst_n,
      .aw_valid(reg_aw_valid), .aw_ready(reg_aw_ready), .aw_data(reg_aw_data),
      .w_valid (reg_w_valid),  .w_ready (reg_w_ready),  .w_data (reg_w_data),
      .b_valid (reg_b_valid),  .b_ready (reg_b_ready),  .b_data (reg_b_data),
      .ar_valid(reg_ar_valid), .ar_ready(reg_ar_ready), .ar_data(reg_ar_data),
      .r_valid (reg_r_valid),  .r_ready (reg_r_ready),  .r_data (reg_r_data),
      .miss_count, .miss_clr
   );

   fake_responder u_fake (
      .clk, .rst_n,
      .aw_valid(fake_aw_valid), .aw_ready(fake_aw_ready), .aw_data(fake_aw_data),
      .w_valid (fake_w_valid),  .w_ready (fake_w_ready),  .w_data (fake_w_data),
      .b_valid (fake_b_valid),  .b_ready (fake_b_ready),  .b_data (fake_b_data),
      .ar_valid(fake_ar_valid), .ar_ready(fake_ar_ready), .ar_data(fake_ar_data),
      .r_valid (fake_r_valid),  .r_ready (fake_r_ready),  .r_data (fake_r_data)
   );

   miss_counter u_miss (
      .clk, .rst_n,
      .miss_inc,
      .clr  (miss_clr),
      .count(miss_count)
   );

endmodule

// ==== design/miss_counter.sv ====
/*
 Saturating count of fake responder accesses
 Clear wins over an increment in the same cycle
*/
`timescale 1ns/1ps
`include "csr_cfg.svh"

module miss_counter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [1:0]             miss_inc,
   input  logic                   clr,
   output logic [`CSR_DATA_W-1:0] count
);

   // One extra bit catches the wrap
   logic [`CSR_DATA_W:0] sum;

   assign sum = {1'b0, count} + miss_inc[0] + miss_inc[1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else if (clr) begin
         count <= '0;
      end else if (sum[`CSR_DATA_W]) begin
         count <= '1;
      end else begin
         count <= sum[`CSR_DATA_W-1:0];
      end
   end

   // Monotonic between clears
   a_no_decrease: assert property (@(posedge clk) disable iff (!rst_n)
      !clr |=> count >= $past(count));

endmodule

// ==== design/fake_responder.sv ====
/*
 Target for addresses past the implemented window
 Reads return zero and every response is OKAY
 Upstream must issue only legal requests since nothing is checked
*/
`timescale 1ns/1ps

module fake_responder
   import axil_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     aw_valid,
   output logic     aw_ready,
   input  axil_ax_t aw_data,
   input  logic     w_valid,
   output logic     w_ready,
   input  axil_w_t  w_data,
   output logic     b_valid,
   input  logic     b_ready,
   output axil_b_t  b_data,
   input  logic     ar_valid,
   output logic     ar_ready,
   input  axil_ax_t ar_data,
   output logic     r_valid,
   input  logic     r_ready,
   output axil_r_t  r_data
);

   // Fixed response payloads since address and data are ignored
   assign r_data = '{data: '0, resp: RESP_OKAY};
   assign b_data = '{resp: RESP_OKAY};

   // ------------------------------
   // Read channel
   // ------------------------------
   // Ready low in the first cycle after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
      end else if (ar_valid && ar_ready) begin
         // Busy until the response is taken
         ar_ready <= 1'b0;
         r_valid  <= 1'b1;
      end else if (r_valid && r_ready) begin
         r_valid  <= 1'b0;
         ar_ready <= 1'b1;
      end else if (!r_valid) begin
         ar_ready <= 1'b1;
      end
   end

   // ------------------------------
   // Write channels
   // ------------------------------
   // W opens only once the address is in
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
      end else if (aw_valid && aw_ready) begin
         aw_ready <= 1'b0;
         w_ready  <= 1'b1;
      end else if (w_valid && w_ready) begin
         // Response follows the data accept
         w_ready  <= 1'b0;
         b_valid  <= 1'b1;
      end else if (b_valid && b_ready) begin
         b_valid  <= 1'b0;
         aw_ready <= 1'b1;
      end else if (!w_ready && !b_valid) begin
         aw_ready <= 1'b1;
      end
   end

   // Neither direction takes a request while its response is pending
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      !(r_valid && ar_ready) && !(b_valid && (aw_ready || w_ready)));

endmodule

// ==== design/csr_regfile.sv ====
/*
 ID, two scratch registers and the miss counter view
 Address bits 3:2 select the register, strobes apply to scratch only
*/
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regfile
   import axil_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  axil_ax_t               aw_data,
   input  logic                   w_valid,
   output logic                   w_ready,
   input  axil_w_t                w_data,
   output logic                   b_valid,
   input  logic                   b_ready,
   output axil_b_t                b_data,
   input  logic                   ar_valid,
   output logic                   ar_ready,
   input  axil_ax_t               ar_data,
   output logic                   r_valid,
   input  logic                   r_ready,
   output axil_r_t                r_data,
   input  logic [`CSR_DATA_W-1:0] miss_count,
   output logic                   miss_clr
);

   logic [`CSR_DATA_W-1:0] rdata;
   logic [`CSR_DATA_W-1:0] scratch0;
   logic [`CSR_DATA_W-1:0] scratch1;
   logic [`CSR_ADDR_W-1:0] waddr;
   csr_reg_e               rd_sel;
   csr_reg_e               wr_sel;

   // Byte-strobed merge of new data into a stored word
   function automatic logic [`CSR_DATA_W-1:0] merge(
      input logic [`CSR_DATA_W-1:0]   old,
      input logic [`CSR_DATA_W-1:0]   data,
      input logic [`CSR_DATA_W/8-1:0] strb
   );
      logic [`CSR_DATA_W-1:0] res;
      res = old;
      for (int i = 0; i < `CSR_DATA_W/8; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = data[8*i +: 8];
         end
      end
      return res;
   endfunction

   assign rd_sel = csr_reg_e'(ar_data.addr[REG_IDX_W+1:2]);
   assign wr_sel = csr_reg_e'(waddr[REG_IDX_W+1:2]);
   assign r_data = '{data: rdata, resp: RESP_OKAY};
   assign b_data = '{resp: RESP_OKAY};

   // ------------------------------
   // Read channel
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
      end else if (ar_valid && ar_ready) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b1;
      end else if (r_valid && r_ready) begin
         r_valid  <= 1'b0;
         ar_ready <= 1'b1;
      end else if (!r_valid) begin
         ar_ready <= 1'b1;
      end
   end

   // Captured at accept, miss count is a snapshot
   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         case (rd_sel)
            REG_ID:       rdata <= `CSR_ID_VALUE;
            REG_SCRATCH0: rdata <= scratch0;
            REG_SCRATCH1: rdata <= scratch1;
            default:      rdata <= miss_count;
         endcase
      end
   end

   // ------------------------------
   // Write channels
   // ------------------------------
   // Data is taken only after the address, response on the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
      end else if (aw_valid && aw_ready) begin
         aw_ready <= 1'b0;
         w_ready  <= 1'b1;
      end else if (w_valid && w_ready) begin
         w_ready  <= 1'b0;
         b_valid  <= 1'b1;
      end else if (b_valid && b_ready) begin
         b_valid  <= 1'b0;
         aw_ready <= 1'b1;
      end else if (!w_ready && !b_valid) begin
         aw_ready <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         waddr <= aw_data.addr;
      end
   end

   // Register updates, ID is read only
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch0 <= '0;
         scratch1 <= '0;
         miss_clr <= 1'b0;
      end else begin
         miss_clr <= w_valid && w_ready && (wr_sel == REG_MISS);
         if (w_valid && w_ready && wr_sel == REG_SCRATCH0) begin
            scratch0 <= merge(scratch0, w_data.data, w_data.strb);
         end
         if (w_valid && w_ready && wr_sel == REG_SCRATCH1) begin
            scratch1 <= merge(scratch1, w_data.data, w_data.strb);
         end
      end
   end

endmodule

// ==== design/csr_route_fsm.sv ====
/*
 Steers each request to the register file or the fake responder
 One read and one write in flight with the target chosen by address
 miss_inc bit 0 is the read side, bit 1 the write side
*/
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_route_fsm
   import axil_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   // Slice side
   input  logic     aw_valid,
   output logic     aw_ready,
   input  axil_ax_t aw_data,
   input  logic     w_valid,
   output logic     w_ready,
   input  axil_w_t  w_data,
   input  logic     ar_valid,
   output logic     ar_ready,
   input  axil_ax_t ar_data,
   // Host responses
   output logic     b_valid,
   input  logic     b_ready,
   output axil_b_t  b_data,
   output logic     r_valid,
   input  logic     r_ready,
   output axil_r_t  r_data,
   // Register file
   output logic     reg_aw_valid,
   input  logic     reg_aw_ready,
   output axil_ax_t reg_aw_data,
   output logic     reg_w_valid,
   input  logic     reg_w_ready,
   output axil_w_t  reg_w_data,
   output logic     reg_ar_valid,
   input  logic     reg_ar_ready,
   output axil_ax_t reg_ar_data,
   input  logic     reg_b_valid,
   output logic     reg_b_ready,
   input  axil_b_t  reg_b_data,
   input  logic     reg_r_valid,
   output logic     reg_r_ready,
   input  axil_r_t  reg_r_data,
   // Fake responder
   output logic     fake_aw_valid,
   input  logic     fake_aw_ready,
   output axil_ax_t fake_aw_data,
   output logic     fake_w_valid,
   input  logic     fake_w_ready,
   output axil_w_t  fake_w_data,
   output logic     fake_ar_valid,
   input  logic     fake_ar_ready,
   output axil_ax_t fake_ar_data,
   input  logic     fake_b_valid,
   output logic     fake_b_ready,
   input  axil_b_t  fake_b_data,
   input  logic     fake_r_valid,
   output logic     fake_r_ready,
   input  axil_r_t  fake_r_data,
   output logic [1:0] miss_inc
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FWD,
      ST_RESP
   } route_st_e;

   route_st_e rd_state;
   route_st_e wr_state;
   logic      rd_fake;
   logic      wr_fake;
   axil_ax_t  rd_req;
   axil_ax_t  wr_req;
   axil_w_t   wr_dat;
   logic      aw_mark;
   logic      w_mark;
   logic      fwd_aw;
   logic      fwd_w;
   logic      aw_done;
   logic      w_done;

   // ------------------------------
   // Read direction
   // ------------------------------
   assign ar_ready      = (rd_state == ST_IDLE);
   assign reg_ar_valid  = (rd_state == ST_FWD) && !rd_fake;
   assign fake_ar_valid = (rd_state == ST_FWD) && rd_fake;
   assign reg_ar_data   = rd_req;
   assign fake_ar_data  = rd_req;

   // Response path from the selected target only
   assign r_valid      = (rd_state == ST_RESP) && (rd_fake ? fake_r_valid : reg_r_valid);
   assign r_data       = rd_fake ? fake_r_data : reg_r_data;
   assign reg_r_ready  = (rd_state == ST_RESP) && !rd_fake && r_ready;
   assign fake_r_ready = (rd_state == ST_RESP) && rd_fake && r_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_state <= ST_IDLE;
         rd_fake  <= 1'b0;
      end else begin
         case (rd_state)
            ST_IDLE: begin
               if (ar_valid) begin
                  rd_state <= ST_FWD;
                  rd_fake  <= (ar_data.addr >= `CSR_IMPL_LIMIT);
               end
            end
            ST_FWD: begin
               if (reg_ar_valid && reg_ar_ready || fake_ar_valid && fake_ar_ready) begin
                  rd_state <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (r_valid && r_ready) begin
                  rd_state <= ST_IDLE;
               end
            end
            default: rd_state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         rd_req <= ar_data;
      end
   end

   // ------------------------------
   // Write direction
   // ------------------------------
   // Mark set once a channel is done in the current phase
   // In IDLE the slice handed it over and in FWD the target took it
   assign aw_ready = (wr_state == ST_IDLE) && !aw_mark;
   assign w_ready  = (wr_state == ST_IDLE) && !w_mark;
   assign fwd_aw   = (wr_state == ST_FWD) && !aw_mark;
   assign fwd_w    = (wr_state == ST_FWD) && !w_mark;

   assign reg_aw_valid  = fwd_aw && !wr_fake;
   assign fake_aw_valid = fwd_aw && wr_fake;
   assign reg_w_valid   = fwd_w && !wr_fake;
   assign fake_w_valid  = fwd_w && wr_fake;
   assign reg_aw_data   = wr_req;
   assign fake_aw_data  = wr_req;
   assign reg_w_data    = wr_dat;
   assign fake_w_data   = wr_dat;

   // Channel finished in this phase earlier or on this edge
   assign aw_done = aw_mark || (aw_valid && aw_ready)
                  || (fwd_aw && (wr_fake ? fake_aw_ready : reg_aw_ready));
   assign w_done  = w_mark || (w_valid && w_ready)
                  || (fwd_w && (wr_fake ? fake_w_ready : reg_w_ready));

   assign b_valid      = (wr_state == ST_RESP) && (wr_fake ? fake_b_valid : reg_b_valid);
   assign b_data       = wr_fake ? fake_b_data : reg_b_data;
   assign reg_b_ready  = (wr_state == ST_RESP) && !wr_fake && b_ready;
   assign fake_b_ready = (wr_state == ST_RESP) && wr_fake && b_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_state <= ST_IDLE;
         wr_fake  <= 1'b0;
         aw_mark  <= 1'b0;
         w_mark   <= 1'b0;
      end else begin
         // Target is decided when the address is taken
         if (aw_valid && aw_ready) begin
            wr_fake <= (aw_data.addr >= `CSR_IMPL_LIMIT);
         end
         case (wr_state)
            ST_IDLE, ST_FWD: begin
               if (aw_done && w_done) begin
                  wr_state <= (wr_state == ST_IDLE) ? ST_FWD : ST_RESP;
                  aw_mark  <= 1'b0;
                  w_mark   <= 1'b0;
               end else begin
                  aw_mark <= aw_done;
                  w_mark  <= w_done;
               end
            end
            ST_RESP: begin
               if (b_valid && b_ready) begin
                  wr_state <= ST_IDLE;
               end
            end
            default: wr_state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         wr_req <= aw_data;
      end
      if (w_valid && w_ready) begin
         wr_dat <= w_data;
      end
   end

   // One pulse per request handed to the fake responder
   assign miss_inc[0] = fake_ar_valid && fake_ar_ready;
   assign miss_inc[1] = fake_aw_valid && fake_aw_ready;

   // Selected target agrees with the held address outside IDLE
   a_rd_one_target: assert property (@(posedge clk) disable iff (!rst_n)
      rd_state != ST_IDLE |-> rd_fake == (rd_req.addr >= `CSR_IMPL_LIMIT));
   a_wr_one_target: assert property (@(posedge clk) disable iff (!rst_n)
      wr_state != ST_IDLE |-> wr_fake == (wr_req.addr >= `CSR_IMPL_LIMIT));

   // Unselected target never holds a response
   a_rd_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
      !(rd_fake ? reg_r_valid : fake_r_valid));
   a_wr_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_fake ? reg_b_valid : fake_b_valid));

endmodule

// ==== design/axil_req_slice.sv ====
/*
 One-entry request buffer, ready is registered
 Throughput is one transfer every two cycles
*/
`timescale 1ns/1ps

module axil_req_slice
   import axil_pkg::*;
#(
   parameter type payload_t = axil_ax_t
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     full;
   payload_t entry;

   assign out_valid = full;
   assign out_data  = entry;

   // Ready stays low in reset and while the entry is occupied
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full     <= 1'b0;
         in_ready <= 1'b0;
      end else if (in_valid && in_ready) begin
         full     <= 1'b1;
         in_ready <= 1'b0;
      end else if (out_valid && out_ready) begin
         full     <= 1'b0;
         in_ready <= 1'b1;
      end else begin
         in_ready <= !full;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         entry <= in_data;
      end
   end

   // Held entry must not change until the router takes it
   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== design/axil_pkg.sv ====
/*
 AXI-Lite channel payloads and CSR register indices
 Only OKAY is ever produced by the targets
*/
`include "csr_cfg.svh"

package axil_pkg;

   // Response codes, SLVERR kept for completeness
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_e;

   // AW and AR share one payload
   typedef struct packed {
      logic [`CSR_ADDR_W-1:0] addr;
   } axil_ax_t;

   typedef struct packed {
      logic [`CSR_DATA_W-1:0]   data;
      logic [`CSR_DATA_W/8-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      axil_resp_e resp;
   } axil_b_t;

   typedef struct packed {
      logic [`CSR_DATA_W-1:0] data;
      axil_resp_e             resp;
   } axil_r_t;

   // Register index, taken from address bits above the byte offset
   localparam int unsigned REG_IDX_W = $clog2(`CSR_NUM_REGS);

   typedef enum logic [REG_IDX_W-1:0] {
      REG_ID,
      REG_SCRATCH0,
      REG_SCRATCH1,
      REG_MISS
   } csr_reg_e;

endpackage

// ==== design/csr_cfg.svh ====
/*
 Build-time constants for the CSR endpoint
 CSR_IMPL_LIMIT must equal 4 * CSR_NUM_REGS
*/
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Bus geometry
`define CSR_ADDR_W 12
`define CSR_DATA_W 32

// Implemented register window, byte addresses below the limit
`define CSR_IMPL_LIMIT 12'h010
`define CSR_NUM_REGS 4

// Fixed value of the ID register
`define CSR_ID_VALUE 32'h5C51_0001

`endif
